// File: include/iir_formats.svh
`ifndef IIR_FORMATS_SVH
`define IIR_FORMATS_SVH

// signed input and output samples
`define IIR_SAMPLE_W 8

// signed coefficients and the stored feedback outputs
`define IIR_COEF_W 16

// result accumulator, sums wrap at this width
`define IIR_ACC_W 27

// arithmetic right shift on the feedback products
`define IIR_FB_SHIFT 3

`endif

// File: design/iir_pkg.sv
`default_nettype none

`include "iir_formats.svh"

package iir_pkg;

	// a1 sits in the top bits, b2 in the bottom bits
	typedef struct packed {
		logic signed [`IIR_COEF_W-1:0] a1;
		logic signed [`IIR_COEF_W-1:0] a2;
		logic signed [`IIR_COEF_W-1:0] b0;
		logic signed [`IIR_COEF_W-1:0] b1;
		logic signed [`IIR_COEF_W-1:0] b2;
	} coef_set_t;

	typedef struct packed {
		logic run_active;
		logic clear_history;
	} run_status_t;

	typedef enum logic [1:0] {
		seq_idle,
		seq_load,
		seq_run,
		seq_finish
	} seq_state_t;

endpackage

`default_nettype wire

// File: design/filter_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "iir_formats.svh"

module filter_sequencer
	import iir_pkg::*;
#(
	parameter int SAMPLE_BUDGET = 100
)
(
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    iir_start,
	input  wire [`IIR_COEF_W-1:0]  params,
	input  wire                    sample_done,
	output coef_set_t              coefs,
	output run_status_t            status,
	output logic                   iir_done
);

	localparam int CNT_W = $clog2(SAMPLE_BUDGET + 1);

	seq_state_t       state;
	logic [2:0]       load_idx;
	logic [CNT_W-1:0] sample_cnt;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= seq_idle;
			load_idx   <= '0;
			sample_cnt <= '0;
			coefs      <= '0;
			status     <= '0;
		end
		else
		begin
			// history clear is a single cycle pulse
			status.clear_history <= 1'b0;

			case (state)
				seq_idle:
				begin
					// a1 is already on params in the start cycle
					if (iir_start)
					begin
						coefs.a1 <= params;
						load_idx <= 3'd1;
						state    <= seq_load;
					end
				end
				seq_load:
				begin
					load_idx <= load_idx + 3'd1;
					case (load_idx)
						3'd1: coefs.a2 <= params;
						3'd2: coefs.b0 <= params;
						3'd3: coefs.b1 <= params;
						default:
						begin
							// last word is b2, the run opens next cycle
							coefs.b2             <= params;
							sample_cnt           <= '0;
							status.run_active    <= 1'b1;
							status.clear_history <= 1'b1;
							state                <= seq_run;
						end
					endcase
				end
				seq_run:
				begin
					if (sample_done)
					begin
						sample_cnt <= sample_cnt + 1'b1;
						if (sample_cnt == CNT_W'(SAMPLE_BUDGET - 1))
						begin
							status.run_active <= 1'b0;
							state             <= seq_finish;
						end
					end
				end
				seq_finish: state <= seq_idle;
				default: state <= seq_idle;
			endcase
		end
	end

	// done marks the single cycle spent in finish
	assign iir_done = (state == seq_finish);

	// done closes the run on its last sample and lasts one cycle
	a_done_single: assert property (@(posedge clk) disable iff (reset)
		iir_done |-> $past(sample_done) ##1 !iir_done);

	// the datapath only completes samples that the run granted
	a_done_in_run: assert property (@(posedge clk) disable iff (reset)
		sample_done |-> state == seq_run);

endmodule

`default_nettype wire

// File: design/iir_biquad.sv
`timescale 1ns/1ps
`default_nettype none

`include "iir_formats.svh"

module iir_biquad
	import iir_pkg::*;
#(
	parameter int SETTLE_CYCLES = 4
)
(
	input  wire                              clk,
	input  wire                              reset,
	input  wire coef_set_t                   coefs,
	input  wire run_status_t                 status,
	input  wire                              start,
	input  wire signed [`IIR_SAMPLE_W-1:0]   din,
	output logic                             ready,
	output logic signed [`IIR_SAMPLE_W-1:0]  dout,
	output logic                             out_valid,
	output logic                             sample_done
);

	localparam int SETTLE_W = $clog2(SETTLE_CYCLES + 1);
	localparam int FB_W = 2 * `IIR_COEF_W + 1;
	// start cycle to out_valid
	localparam int LATENCY = 5 + SETTLE_CYCLES;

	typedef enum logic [2:0] {
		st_wait,
		st_latch,
		st_feedback,
		st_feedfwd,
		st_accum,
		st_settle,
		st_output
	} bq_state_t;

	bq_state_t state;
	logic [SETTLE_W-1:0] settle_cnt;
	logic accept;
	logic result_load;

	// input latch and input history
	logic signed [`IIR_SAMPLE_W-1:0] in_q;
	logic signed [`IIR_SAMPLE_W-1:0] uk;
	logic signed [`IIR_SAMPLE_W-1:0] uk1;
	logic signed [`IIR_SAMPLE_W-1:0] uk2;

	// output history, upper accumulator bits
	logic signed [`IIR_COEF_W-1:0] yk1;
	logic signed [`IIR_COEF_W-1:0] yk2;

	logic signed [FB_W-1:0] fb_prod_sum;
	logic signed [FB_W-1:0] fb_shifted;
	logic signed [`IIR_ACC_W-1:0] ff_prod_sum;
	logic signed [`IIR_ACC_W-1:0] fb_q;
	logic signed [`IIR_ACC_W-1:0] ff_q;
	logic signed [`IIR_ACC_W-1:0] acc;

	// no sample in the clear cycle, history is being zeroed
	assign ready = (state == st_wait) && status.run_active && !status.clear_history;
	assign accept = ready && start;
	assign result_load = (state == st_settle) && (settle_cnt == '0);
	assign out_valid = (state == st_output);
	assign sample_done = (state == st_output);

	// products are formed at full width, the cut to the accumulator wraps
	assign fb_prod_sum = yk1 * $signed(coefs.a1) + yk2 * $signed(coefs.a2);
	assign fb_shifted = fb_prod_sum >>> `IIR_FB_SHIFT;
	assign ff_prod_sum = uk * $signed(coefs.b0) + uk1 * $signed(coefs.b1)
		+ uk2 * $signed(coefs.b2);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state      <= st_wait;
			settle_cnt <= '0;
			in_q       <= '0;
			dout       <= '0;
		end
		else
		begin
			case (state)
				st_wait:
				begin
					if (accept)
					begin
						in_q  <= din;
						state <= st_latch;
					end
				end
				st_latch: state <= st_feedback;
				st_feedback: state <= st_feedfwd;
				st_feedfwd: state <= st_accum;
				st_accum:
				begin
					settle_cnt <= SETTLE_W'(SETTLE_CYCLES - 1);
					state      <= st_settle;
				end
				st_settle:
				begin
					// multipliers get SETTLE_CYCLES before the result is taken
					if (result_load)
					begin
						dout  <= acc[`IIR_ACC_W-1 -: `IIR_SAMPLE_W];
						state <= st_output;
					end
					else
						settle_cnt <= settle_cnt - 1'b1;
				end
				default: state <= st_wait;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == st_feedback)
			fb_q <= fb_shifted[`IIR_ACC_W-1:0];
		if (state == st_feedfwd)
			ff_q <= ff_prod_sum;
		if (state == st_accum)
			acc <= fb_q + ff_q;

		if (status.clear_history)
		begin
			uk  <= '0;
			uk1 <= '0;
			uk2 <= '0;
			yk1 <= '0;
			yk2 <= '0;
		end
		else
		begin
			// new sample enters the input delay line
			if (state == st_latch)
			begin
				uk  <= in_q;
				uk1 <= uk;
				uk2 <= uk1;
			end
			if (result_load)
			begin
				yk1 <= acc[`IIR_ACC_W-1 -: `IIR_COEF_W];
				yk2 <= yk1;
			end
		end
	end

	// history takes the sample of the accepted cycle and not a later stray one
	a_ignored_start: assert property (@(posedge clk) disable iff (reset)
		accept |-> ##2 (uk == $past(din, 2)));

	a_latency: assert property (@(posedge clk) disable iff (reset)
		accept |-> ##LATENCY out_valid);

endmodule

`default_nettype wire

// File: design/iir_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "iir_formats.svh"

module iir_top
	import iir_pkg::*;
#(
	parameter int SAMPLE_BUDGET = 100,
	parameter int SETTLE_CYCLES = 4
)
(
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              iir_start,
	input  wire [`IIR_COEF_W-1:0]            params,
	input  wire                              start,
	input  wire signed [`IIR_SAMPLE_W-1:0]   din,
	output wire signed [`IIR_SAMPLE_W-1:0]   dout,
	output wire                              ready,
	output wire                              out_valid,
	output wire                              iir_done
);

	coef_set_t   coefs;
	run_status_t status;
	logic        sample_done;

	// coefficient loading and run budget
	filter_sequencer #(
		.SAMPLE_BUDGET (SAMPLE_BUDGET)
	) i_filter_sequencer (
		.clk         (clk),
		.reset       (reset),
		.iir_start   (iir_start),
		.params      (params),
		.sample_done (sample_done),
		.coefs       (coefs),
		.status      (status),
		.iir_done    (iir_done)
	);

	iir_biquad #(
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) i_iir_biquad (
		.clk         (clk),
		.reset       (reset),
		.coefs       (coefs),
		.status      (status),
		.start       (start),
		.din         (din),
		.ready       (ready),
		.dout        (dout),
		.out_valid   (out_valid),
		.sample_done (sample_done)
	);

endmodule

`default_nettype wire

// File: verification/iir_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "iir_formats.svh"

module iir_checker
#(
	parameter int SAMPLE_BUDGET = 6,
	parameter int MAX_TESTS = 16
)
(
	input  wire                      clk,
	input  wire                      reset,
	input  wire                      iir_start,
	input  wire                      ready,
	input  wire                      out_valid,
	input  wire                      iir_done,
	input  wire [`IIR_SAMPLE_W-1:0]  dout,
	output int                       error_count,
	output int                       output_count,
	output int                       done_count
);

	reg [8*16-1:0] names [0:MAX_TESTS-1];
	reg [`IIR_SAMPLE_W-1:0] exp_mem [0:MAX_TESTS*SAMPLE_BUDGET-1];
	reg [`IIR_SAMPLE_W-1:0] held;
	int num_exp;
	int num_names;
	int test_errors;
	int idx;
	logic idle;
	logic expect_done;

	task read_expected();
		integer fd;
		integer code;
		reg [8*128-1:0] line;
		reg [8*16-1:0] nm;
		reg [`IIR_SAMPLE_W-1:0] y [0:5];
		begin
			fd = $fopen("verification/iir_stim.txt", "r");
			if (fd == 0)
				$display("checker cannot open the stimulus file");
			else
			begin
				while (!$feof(fd))
				begin
					line = 0;
					code = $fgets(line, fd);
					if ($sscanf(line, "test %s", nm) == 1 && num_names < MAX_TESTS)
					begin
						names[num_names] = nm;
						num_names = num_names + 1;
					end
					code = $sscanf(line, "check %h %h %h %h %h %h",
						y[0], y[1], y[2], y[3], y[4], y[5]);
					if (code == 6 && num_exp < MAX_TESTS * SAMPLE_BUDGET)
					begin
						for (int k = 0; k < 6; k++)
							exp_mem[num_exp + k] = y[k];
						num_exp = num_exp + 6;
					end
				end
				$fclose(fd);
			end
		end
	endtask

	initial
	begin
		error_count = 0;
		output_count = 0;
		done_count = 0;
		num_exp = 0;
		num_names = 0;
		test_errors = 0;
		read_expected();
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			idle = 1'b1;
			expect_done = 1'b0;
			held = '0;
		end
		else
		begin
			if (iir_start)
				idle = 1'b0;
			if (idle && (ready || out_valid))
			begin
				$display("ready or out_valid went high while no run was open");
				error_count++;
				test_errors++;
			end
			// dout must hold between results
			if (!out_valid && dout !== held)
			begin
				$display("dout changed without out_valid");
				error_count++;
				test_errors++;
			end
			if (expect_done)
			begin
				if (!iir_done)
				begin
					$display("iir_done missing in the cycle after the last output of a run");
					error_count++;
					test_errors++;
				end
				expect_done = 1'b0;
			end
			else if (iir_done)
			begin
				$display("iir_done pulsed where no run was ending");
				error_count++;
				test_errors++;
			end
			if (iir_done)
			begin
				idx = (done_count < num_names) ? done_count : 0;
				if (test_errors == 0)
					$display("test %0s: ok", names[idx]);
				else
					$display("test %0s: %0d errors", names[idx], test_errors);
				test_errors = 0;
				done_count++;
				idle = 1'b1;
			end
			if (out_valid)
			begin
				if (output_count >= num_exp)
				begin
					$display("more outputs than expected values");
					error_count++;
					test_errors++;
				end
				else if (dout !== exp_mem[output_count])
				begin
					$display("FAILED %0s expected %h actual %h",
						names[output_count / SAMPLE_BUDGET], exp_mem[output_count], dout);
					error_count++;
					test_errors++;
				end
				held = dout;
				output_count++;
				if (output_count % SAMPLE_BUDGET == 0)
					expect_done = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/tb_iir.sv
`timescale 1ns/1ps
`default_nettype none

`include "iir_formats.svh"

module tb_iir;

	localparam int SAMPLE_BUDGET = 6;
	localparam int SETTLE_CYCLES = 4;
	localparam int RESET_CYCLES = 8;
	localparam int MAX_TESTS = 16;

	logic clk;
	logic reset;
	logic iir_start;
	logic start;
	logic [`IIR_COEF_W-1:0] params;
	logic [`IIR_SAMPLE_W-1:0] din;
	wire [`IIR_SAMPLE_W-1:0] dout;
	wire ready;
	wire out_valid;
	wire iir_done;

	int error_count;
	int output_count;
	int done_count;
	int num_tests = 0;
	int cycle_limit = 0;
	int cycle_count = 0;

	reg [`IIR_COEF_W-1:0] coef_mem [0:MAX_TESTS*5-1];
	reg [`IIR_SAMPLE_W-1:0] sample_mem [0:MAX_TESTS*SAMPLE_BUDGET-1];

	iir_top #(
		.SAMPLE_BUDGET (SAMPLE_BUDGET),
		.SETTLE_CYCLES (SETTLE_CYCLES)
	) i_iir_top (
		.clk       (clk),
		.reset     (reset),
		.iir_start (iir_start),
		.params    (params),
		.start     (start),
		.din       (din),
		.dout      (dout),
		.ready     (ready),
		.out_valid (out_valid),
		.iir_done  (iir_done)
	);

	iir_checker #(
		.SAMPLE_BUDGET (SAMPLE_BUDGET),
		.MAX_TESTS     (MAX_TESTS)
	) i_iir_checker (
		.clk          (clk),
		.reset        (reset),
		.iir_start    (iir_start),
		.ready        (ready),
		.out_valid    (out_valid),
		.iir_done     (iir_done),
		.dout         (dout),
		.error_count  (error_count),
		.output_count (output_count),
		.done_count   (done_count)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task read_tests();
		integer fd;
		integer code;
		reg [8*128-1:0] line;
		reg [8*16-1:0] nm;
		reg [`IIR_COEF_W-1:0] w [0:4];
		reg [`IIR_SAMPLE_W-1:0] x [0:5];
		begin
			fd = $fopen("verification/iir_stim.txt", "r");
			if (fd != 0)
			begin
				while (!$feof(fd))
				begin
					line = 0;
					code = $fgets(line, fd);
					code = $sscanf(line, "test %s %h %h %h %h %h %h %h %h %h %h %h", nm,
						w[0], w[1], w[2], w[3], w[4], x[0], x[1], x[2], x[3], x[4], x[5]);
					if (code == 12 && num_tests < MAX_TESTS)
					begin
						for (int k = 0; k < 5; k++)
							coef_mem[num_tests * 5 + k] = w[k];
						for (int k = 0; k < SAMPLE_BUDGET; k++)
							sample_mem[num_tests * SAMPLE_BUDGET + k] = x[k];
						num_tests = num_tests + 1;
					end
				end
				$fclose(fd);
			end
		end
	endtask

	// a1 goes out with the iir_start pulse, the rest follow
	// start is held through the load while ready is low and must be dropped
	task load_coefs(input int t);
		begin
			@(negedge clk);
			iir_start = 1'b1;
			params = coef_mem[t * 5];
			start = 1'b1;
			din = 8'h3c;
			for (int k = 1; k < 5; k++)
			begin
				@(negedge clk);
				iir_start = 1'b0;
				params = coef_mem[t * 5 + k];
			end
			@(negedge clk);
			params = '0;
			start = 1'b0;
			din = '0;
		end
	endtask

	// stray strobes follow each accepted sample and must be ignored
	task send_sample(input int i, input bit stray_iir_start);
		begin
			@(negedge clk);
			while (!ready)
				@(negedge clk);
			start = 1'b1;
			din = sample_mem[i];
			@(negedge clk);
			din = 8'h55;
			if (stray_iir_start)
			begin
				iir_start = 1'b1;
				params = 16'h7abc;
			end
			@(negedge clk);
			start = 1'b0;
			iir_start = 1'b0;
			params = '0;
			din = '0;
		end
	endtask

	task wait_done();
		begin
			@(negedge clk);
			while (!iir_done)
				@(negedge clk);
		end
	endtask

	initial
	begin
		reset = 1'b1;
		iir_start = 1'b0;
		start = 1'b0;
		params = '0;
		din = '0;
		read_tests();
		if (num_tests == 0)
		begin
			$display("no tests could be read from the stimulus file");
			$display("Testbench failed");
			$finish;
		end
		else
		begin
			cycle_limit = num_tests * (6 + SAMPLE_BUDGET * 11 + 10) + RESET_CYCLES;
			repeat (RESET_CYCLES) @(negedge clk);
			reset = 1'b0;
			// outputs must stay quiet before the first run
			repeat (3) @(negedge clk);
			for (int t = 0; t < num_tests; t++)
			begin
				load_coefs(t);
				for (int k = 0; k < SAMPLE_BUDGET; k++)
					send_sample(t * SAMPLE_BUDGET + k, k == 2);
				wait_done();
				repeat (4) @(negedge clk);
			end
			repeat (2) @(negedge clk);
			$display("tests %0d, outputs %0d, done pulses %0d, errors %0d",
				num_tests, output_count, done_count, error_count);
			if (error_count == 0 && output_count == num_tests * SAMPLE_BUDGET
				&& done_count == num_tests)
				$display("Testbench passed");
			else
				$display("Testbench failed");
			$finish;
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit)
		begin
			$display("timeout, the tests did not finish within %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
design/iir_pkg.sv
design/filter_sequencer.sv
design/iir_biquad.sv
design/iir_top.sv
verification/iir_checker.sv
verification/tb_iir.sv

// File: verification/iir_stim.txt
# test <name> a1 a2 b0 b1 b2 then six input samples, all hex
# check <six expected dout values>, hex, in output order
test ff_impulse 0000 0000 4000 2000 c000 40 00 00 00 00 00
check 02 01 fe 00 00 00
test fb_step_wrap 4000 4000 7000 7000 7000 7f 7f 7f 7f 7f 7f
check 06 14 30 5a 9f 0e
test fb_step_again 4000 4000 7000 7000 7000 7f 7f 7f 7f 7f 7f
check 06 14 30 5a 9f 0e
test ff_neg_impulse 0000 0000 2000 4000 1000 c0 00 00 00 00 00
check ff fe ff 00 00 00
